// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_arm810 -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_arm810)"; echo "$$out"; \
		echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== dv/tb_arm810.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_arm810;
	import core_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int PROG_LEN = 300;
	localparam int MEM_WORDS = 2048;
	localparam int TIMEOUT_CYCLES = (PROG_LEN + 2) * 12;
	localparam int HALT_AT = 150;

	logic clk, rst, halt;
	ptr bus_addr;
	logic bus_start, bus_write;
	logic bus_ready = 1'b0;
	word bus_data_rd = '0;
	word bus_data_wr;
	logic [3:0] bus_data_be;
	logic halted, breakpoint;

	word mem [0:MEM_WORDS-1];
	word ref_regs [0:14];
	// n, z, c, v.
	logic [3:0] ref_flags;
	// word address over data.
	logic [61:0] store_queue [$];
	integer seed;
	int mismatches = 0;
	int failures = 0;
	int stores_seen = 0;
	int fetches_seen = 0;
	ptr next_fetch;

	// the bus transfer being served.
	logic in_xfer = 1'b0;
	int wait_left;
	ptr req_addr;
	logic req_write;
	word req_data;
	logic [3:0] req_be;

	arm810 i_dut
	(
		.clk(clk),
		.rst(rst),
		.halt(halt),
		.bus_addr(bus_addr),
		.bus_start(bus_start),
		.bus_write(bus_write),
		.bus_ready(bus_ready),
		.bus_data_rd(bus_data_rd),
		.bus_data_wr(bus_data_wr),
		.bus_data_be(bus_data_be),
		.halted(halted),
		.breakpoint(breakpoint)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic word encode_dp(logic [3:0] cond, logic [3:0] op, logic s,
		logic [3:0] rn, logic [3:0] rd, logic imm, logic [11:0] op2);
		return {cond, 2'b00, imm, op, s, rn, rd, op2};
	endfunction

	// str rd, [r13, #+/-offset].
	function automatic word encode_str(logic [3:0] cond, logic up, logic [3:0] rd,
		logic [11:0] offset);
		return {cond, 3'b010, 1'b1, up, 3'b000, 4'd13, rd, offset};
	endfunction

	function automatic logic condition_passes(logic [3:0] cond, logic [3:0] f);
		logic n, z, c, v;
		n = f[3];
		z = f[2];
		c = f[1];
		v = f[0];
		case (cond)
			4'h0: return z;
			4'h1: return !z;
			4'h2: return c;
			4'h3: return !c;
			4'h4: return n;
			4'h5: return !n;
			4'h6: return v;
			4'h7: return !v;
			4'h8: return c && !z;
			4'h9: return !c || z;
			4'ha: return n == v;
			4'hb: return n != v;
			4'hc: return !z && n == v;
			4'hd: return z || n != v;
			4'he: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// second operand with its carry, carry in the top bit.
	function automatic logic [32:0] operand2(word insn, word rm_val, logic c_in);
		word val;
		logic carry;
		int amt;
		int rot;
		carry = c_in;
		if (insn[25]) begin
			rot = 2 * insn[11:8];
			val = {24'b0, insn[7:0]};
			if (rot != 0) begin
				val = (val >> rot) | (val << (32 - rot));
				carry = val[31];
			end
		end else begin
			amt = insn[11:7];
			case (insn[6:5])
				2'd0:
					if (amt == 0) begin
						val = rm_val;
					end else begin
						val = rm_val << amt;
						carry = rm_val[32 - amt];
					end
				2'd1:
					if (amt == 0) begin
						val = '0;
						carry = rm_val[31];
					end else begin
						val = rm_val >> amt;
						carry = rm_val[amt - 1];
					end
				2'd2:
					if (amt == 0) begin
						val = {32{rm_val[31]}};
						carry = rm_val[31];
					end else begin
						val = $signed(rm_val) >>> amt;
						carry = rm_val[amt - 1];
					end
				default: begin
					val = (rm_val >> amt) | (rm_val << (32 - amt));
					carry = rm_val[amt - 1];
				end
			endcase
		end
		return {carry, val};
	endfunction

	task automatic build_program();
		logic [3:0] cond, op, rn, rd, rm;
		logic [11:0] op2;
		logic [1:0] kind;
		logic [4:0] amount;
		logic s, imm;
		int ops [10] = '{0, 1, 2, 3, 4, 8, 10, 12, 13, 15};
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = 32'hf000_0000 | i;
		// mov r13, #0x1800 as the store base.
		mem[0] = encode_dp(4'he, 4'hd, 1'b0, 4'd0, 4'd13, 1'b1, {4'd12, 8'h18});
		for (int i = 1; i < PROG_LEN; i++) begin
			cond = rand_below(2) == 0 ? 4'he : 4'(rand_below(16));
			rn = 4'(rand_below(15));
			if (rand_below(5) == 0) begin
				rd = 4'(rand_below(15));
				mem[i] = encode_str(cond, 1'(rand_below(2)), rd, 12'(rand_below(512) * 4));
			end else begin
				op = 4'(ops[rand_below(10)]);
				rd = 4'(rand_below(14));
				if (rd == 4'd13)
					rd = 4'd14;
				s = rand_below(2) == 1 || op == 4'h8 || op == 4'ha;
				imm = rand_below(3) == 0;
				if (imm) begin
					op2 = 12'(rand_below(4096));
				end else begin
					kind = 2'(rand_below(4));
					amount = rand_below(4) == 0 ? 5'd0 : 5'(rand_below(32));
					// no rrx.
					if (kind == 2'd3 && amount == 5'd0)
						amount = 5'd1;
					rm = 4'(rand_below(15));
					op2 = {amount, kind, 1'b0, rm};
				end
				mem[i] = encode_dp(cond, op, s, rn, rd, imm, op2);
			end
		end
		mem[PROG_LEN] = 32'he120_0070;
	endtask

	task automatic run_reference();
		word insn, a, b, result, addr;
		logic [32:0] shifted, sum;
		logic [3:0] op;
		logic carry, ovf;
		for (int r = 0; r < 15; r++)
			ref_regs[r] = '0;
		ref_flags = 4'b0;
		for (int i = 0; i < PROG_LEN; i++) begin
			insn = mem[i];
			if (!condition_passes(insn[31:28], ref_flags))
				continue;
			a = ref_regs[insn[19:16]];
			if (insn[27:26] == 2'b01) begin
				addr = insn[23] ? a + {20'b0, insn[11:0]} : a - {20'b0, insn[11:0]};
				store_queue.push_back({addr[31:2], ref_regs[insn[15:12]]});
				continue;
			end
			op = insn[24:21];
			shifted = operand2(insn, ref_regs[insn[3:0]], ref_flags[1]);
			b = shifted[31:0];
			carry = shifted[32];
			ovf = ref_flags[0];
			case (op)
				4'h0, 4'h8: result = a & b;
				4'h1: result = a ^ b;
				4'hc: result = a | b;
				4'hd: result = b;
				4'hf: result = ~b;
				default: result = '0;
			endcase
			// carry is not-borrow for subtraction.
			if (op == 4'h2 || op == 4'ha) begin
				sum = {1'b0, a} - {1'b0, b};
				result = sum[31:0];
				carry = !sum[32];
				ovf = a[31] != b[31] && result[31] != a[31];
			end else if (op == 4'h3) begin
				sum = {1'b0, b} - {1'b0, a};
				result = sum[31:0];
				carry = !sum[32];
				ovf = b[31] != a[31] && result[31] != b[31];
			end else if (op == 4'h4) begin
				sum = {1'b0, a} + {1'b0, b};
				result = sum[31:0];
				carry = sum[32];
				ovf = a[31] == b[31] && result[31] != a[31];
			end
			if (insn[20])
				ref_flags = {result[31], result == 32'd0, carry, ovf};
			if (op != 4'h8 && op != 4'ha)
				ref_regs[insn[15:12]] = result;
		end
	endtask

	task automatic open_transfer();
		in_xfer = 1'b1;
		req_addr = bus_addr;
		req_write = bus_write;
		req_data = bus_data_wr;
		req_be = bus_data_be;
		wait_left = rand_below(4);
		if (!req_write) begin
			fetches_seen++;
			if (req_addr != next_fetch) begin
				mismatches++;
				$display("Mismatch at %0t ns: fetch from %0h, expected %0h",
					$time, req_addr, next_fetch);
			end
			if (req_addr > PROG_LEN + 1) begin
				failures++;
				$display("fetch from %0h is past the word after the breakpoint", req_addr);
			end
			next_fetch = next_fetch + 30'd1;
		end else if (halted) begin
			failures++;
			$display("store request at %0t ns while the core is halted", $time);
		end
	endtask

	task automatic check_request_held();
		if (!bus_start || bus_addr != req_addr || bus_write != req_write
			|| bus_data_wr != req_data || bus_data_be != req_be) begin
			failures++;
			$display("bus request changed at %0t ns while waiting for ready", $time);
			in_xfer = 1'b0;
		end
	endtask

	task automatic check_store();
		logic [61:0] expected;
		stores_seen++;
		if (store_queue.size() == 0) begin
			failures++;
			$display("store to %0h at %0t ns was not expected", req_addr, $time);
		end else begin
			expected = store_queue.pop_front();
			if (req_addr != expected[61:32] || req_data != expected[31:0] || req_be != 4'hf) begin
				mismatches++;
				$display("Mismatch at %0t ns: store %0h <= %0h be %0h, expected %0h <= %0h be f",
					$time, req_addr, req_data, req_be, expected[61:32], expected[31:0]);
			end
		end
	endtask

	// bus memory with 0 to 3 wait cycles.
	always @(negedge clk) begin
		if (bus_ready)
			in_xfer = 1'b0;
		bus_ready <= 1'b0;
		if (in_xfer)
			check_request_held();
		else if (bus_start)
			open_transfer();
		if (in_xfer) begin
			if (wait_left == 0) begin
				bus_ready <= 1'b1;
				if (req_write)
					check_store();
				else
					bus_data_rd <= req_addr < MEM_WORDS ? mem[req_addr] : '0;
			end else begin
				wait_left--;
			end
		end
	end

	always @(negedge clk) begin
		if (breakpoint && !halted) begin
			failures++;
			$display("breakpoint is high at %0t ns without halted", $time);
		end
	end

	initial begin
		#((TIMEOUT_CYCLES + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout: no breakpoint within %0d cycles", TIMEOUT_CYCLES);
		$display("stores %0d, fetches %0d, mismatches %0d, other errors %0d",
			stores_seen, fetches_seen, mismatches, failures);
		$display("Test failed");
		$finish;
	end

	initial begin
		int cycles;
		rst = 1'b1;
		halt = 1'b0;
		seed = 32'h4a17760e;
		next_fetch = RESET_PC;
		build_program();
		run_reference();
		$display("reference model expects %0d stores", store_queue.size());

		repeat (RESET_CYCLES) @(negedge clk);
		if (bus_start || halted || breakpoint) begin
			failures++;
			$display("bus_start, halted or breakpoint is high in reset");
		end
		rst = 1'b0;
		@(negedge clk);
		if (!bus_start || bus_addr != RESET_PC) begin
			failures++;
			$display("first fetch did not start at the reset address after reset");
		end

		// halt pulse in the middle of the program.
		while (fetches_seen < HALT_AT)
			@(posedge clk);
		@(negedge clk);
		halt = 1'b1;
		cycles = 0;
		while (!halted && cycles < 40) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			failures++;
			$display("core did not halt while halt was high");
		end
		repeat (8) begin
			@(negedge clk);
			if (!halted) begin
				failures++;
				$display("halted fell at %0t ns while halt was high", $time);
			end
		end
		halt = 1'b0;
		cycles = 0;
		while (halted && cycles < 5) begin
			@(negedge clk);
			cycles++;
		end
		if (halted) begin
			failures++;
			$display("core did not resume after halt fell");
		end

		while (!breakpoint)
			@(negedge clk);
		// the last prefetch drains.
		repeat (10) @(negedge clk);
		if (!halted) begin
			failures++;
			$display("core is not halted after the breakpoint");
		end
		if (store_queue.size() != 0) begin
			failures++;
			$display("%0d expected stores never reached the bus", store_queue.size());
		end
		if (next_fetch < PROG_LEN + 1) begin
			failures++;
			$display("only %0d words were fetched before the breakpoint", next_fetch);
		end

		$display("stores %0d, fetches %0d, mismatches %0d, other errors %0d",
			stores_seen, fetches_seen, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/arm810.sv ====
`timescale 1ns/1ps
`default_nettype none

module arm810
(
	input  logic          clk,
	input  logic          rst,

	input  logic          halt,

	output core_pkg::ptr  bus_addr,
	output logic          bus_start,
	output logic          bus_write,
	input  logic          bus_ready,
	input  core_pkg::word bus_data_rd,
	output core_pkg::word bus_data_wr,
	output logic [3:0]    bus_data_be,

	output logic          halted,
	output logic          breakpoint
);
	import core_pkg::*;

	word fetch_insn, rd_value_a, rd_value_b, wr_value, shifter_base, q_shifter, q_alu;
	logic fetch_valid, take, stop, wr_enable, c_shifter, alu_v_valid;
	reg_num ra, rb, rd;
	shifter_control shifter_ctrl;
	alu_op alu_ctrl;
	psr_flags flags, alu_flags;

	core_mem_if fetch_mem ();
	core_mem_if data_mem ();

	core_fetch fetch
	(
		.clk(clk),
		.rst(rst),
		.mem(fetch_mem),
		.insn_valid(fetch_valid),
		.insn(fetch_insn),
		.insn_pc(),
		.take(take),
		.stop(stop)
	);

	core_control control
	(
		.clk(clk),
		.rst(rst),
		.insn_valid(fetch_valid),
		.insn(fetch_insn),
		.take(take),
		.mem(data_mem),
		.halt(halt),
		.halted(halted),
		.breakpoint(breakpoint),
		.stop(stop),
		.rd_r_a(ra),
		.rd_r_b(rb),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.wr_r(rd),
		.wr_enable(wr_enable),
		.wr_value(wr_value),
		.shifter_ctrl(shifter_ctrl),
		.shifter_base(shifter_base),
		.flags(flags),
		.alu_ctrl(alu_ctrl),
		.q_alu(q_alu),
		.alu_flags(alu_flags),
		.alu_v_valid(alu_v_valid)
	);

	core_regs regs
	(
		.clk(clk),
		.rst(rst),
		.rd_r_a(ra),
		.rd_r_b(rb),
		.rd_value_a(rd_value_a),
		.rd_value_b(rd_value_b),
		.wr_r(rd),
		.wr_enable(wr_enable),
		.wr_value(wr_value)
	);

	core_shifter #(.W(32)) shifter
	(
		.ctrl(shifter_ctrl),
		.base(shifter_base),
		.c_in(flags.c),
		.q(q_shifter),
		.c(c_shifter)
	);

	core_alu #(.W(32)) alu
	(
		.op(alu_ctrl),
		.a(rd_value_a),
		.b(q_shifter),
		.c_in(c_shifter),
		.q(q_alu),
		.nzcv(alu_flags),
		.v_valid(alu_v_valid)
	);

	core_bus_arbiter arbiter
	(
		.clk(clk),
		.rst(rst),
		.fetch_port(fetch_mem),
		.data_port(data_mem),
		.bus_addr(bus_addr),
		.bus_start(bus_start),
		.bus_write(bus_write),
		.bus_ready(bus_ready),
		.bus_data_rd(bus_data_rd),
		.bus_data_wr(bus_data_wr),
		.bus_data_be(bus_data_be)
	);

endmodule

`default_nettype wire

// ==== hw/core_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_alu
#(
	parameter int W = 32
)
(
	input  core_pkg::alu_op    op,
	input  logic [W-1:0]       a,
	input  logic [W-1:0]       b,
	input  logic               c_in,
	output logic [W-1:0]       q,
	output core_pkg::psr_flags nzcv,
	output logic               v_valid
);
	import core_pkg::*;

	logic [W:0] sum;
	logic carry, ovf;

	always_comb begin
		sum = '0;
		carry = c_in;
		ovf = 1'b0;
		v_valid = 1'b0;
		q = b;

		case (op)
			ALU_AND, ALU_TST:
				q = a & b;
			ALU_EOR:
				q = a ^ b;
			ALU_ORR:
				q = a | b;
			ALU_MOV:
				q = b;
			ALU_MVN:
				q = ~b;
			// carry is not-borrow.
			ALU_SUB, ALU_CMP: begin
				sum = {1'b0, a} + {1'b0, ~b} + {{W{1'b0}}, 1'b1};
				ovf = a[W-1] != b[W-1] && sum[W-1] != a[W-1];
			end
			ALU_RSB: begin
				sum = {1'b0, b} + {1'b0, ~a} + {{W{1'b0}}, 1'b1};
				ovf = b[W-1] != a[W-1] && sum[W-1] != b[W-1];
			end
			ALU_ADD: begin
				sum = {1'b0, a} + {1'b0, b};
				ovf = a[W-1] == b[W-1] && sum[W-1] != a[W-1];
			end
			default:
				q = b;
		endcase

		if (op == ALU_SUB || op == ALU_CMP || op == ALU_RSB || op == ALU_ADD) begin
			q = sum[W-1:0];
			carry = sum[W];
			v_valid = 1'b1;
		end

		nzcv.n = q[W-1];
		nzcv.z = q == '0;
		nzcv.c = carry;
		nzcv.v = ovf;
	end

endmodule

`default_nettype wire

// ==== hw/core_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_bus_arbiter
(
	input  logic          clk,
	input  logic          rst,

	core_mem_if.arbiter   fetch_port,
	core_mem_if.arbiter   data_port,

	output core_pkg::ptr  bus_addr,
	output logic          bus_start,
	output logic          bus_write,
	input  logic          bus_ready,
	input  core_pkg::word bus_data_rd,
	output core_pkg::word bus_data_wr,
	output logic [3:0]    bus_data_be
);

	logic busy, owner_data, sel_data, grant_data, grant_fetch;

	// data wins a fresh contest, an open grant is kept.
	assign sel_data = busy ? owner_data : data_port.start;
	assign grant_data = sel_data && data_port.start;
	assign grant_fetch = !sel_data && fetch_port.start;

	assign bus_start = grant_data || grant_fetch;
	assign bus_addr = sel_data ? data_port.addr : fetch_port.addr;
	assign bus_write = sel_data ? data_port.write : fetch_port.write;
	assign bus_data_wr = sel_data ? data_port.data_wr : fetch_port.data_wr;
	assign bus_data_be = sel_data ? data_port.be : fetch_port.be;

	assign data_port.ready = grant_data && bus_ready;
	assign fetch_port.ready = grant_fetch && bus_ready;
	assign data_port.data_rd = bus_data_rd;
	assign fetch_port.data_rd = bus_data_rd;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			owner_data <= 1'b0;
		end else if (!busy) begin
			busy <= bus_start && !bus_ready;
			owner_data <= data_port.start;
		end else if (bus_ready) begin
			busy <= 1'b0;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		!(fetch_port.ready && data_port.ready));

	// a waiting transfer keeps its request on the external bus.
	assert property (@(posedge clk) disable iff (rst)
		bus_start && !bus_ready |=> bus_start && $stable(bus_addr)
			&& $stable(bus_write) && $stable(bus_data_wr));

endmodule

`default_nettype wire

// ==== hw/core_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_control
(
	input  logic                     clk,
	input  logic                     rst,

	input  logic                     insn_valid,
	input  core_pkg::word            insn,
	output logic                     take,

	core_mem_if.requester            mem,

	input  logic                     halt,
	output logic                     halted,
	output logic                     breakpoint,
	output logic                     stop,

	output core_pkg::reg_num         rd_r_a,
	output core_pkg::reg_num         rd_r_b,
	input  core_pkg::word            rd_value_a,
	input  core_pkg::word            rd_value_b,
	output core_pkg::reg_num         wr_r,
	output logic                     wr_enable,
	output core_pkg::word            wr_value,

	output core_pkg::shifter_control shifter_ctrl,
	output core_pkg::word            shifter_base,
	output core_pkg::psr_flags       flags,

	output core_pkg::alu_op          alu_ctrl,
	input  core_pkg::word            q_alu,
	input  core_pkg::psr_flags       alu_flags,
	input  logic                     alu_v_valid
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_EXEC,
		CTRL_STORE,
		CTRL_HALTED
	} ctrl_state;

	ctrl_state state;
	word ir, store_addr;
	insn_decode dec;
	logic pass, executing;

	core_decode decode
	(
		.insn(ir),
		.dec(dec)
	);

	function automatic logic cond_pass(cond_code cond, psr_flags f);
		case (cond)
			COND_EQ: return f.z;
			COND_NE: return !f.z;
			COND_CS: return f.c;
			COND_CC: return !f.c;
			COND_MI: return f.n;
			COND_PL: return !f.n;
			COND_VS: return f.v;
			COND_VC: return !f.v;
			COND_HI: return f.c && !f.z;
			COND_LS: return !f.c || f.z;
			COND_GE: return f.n == f.v;
			COND_LT: return f.n != f.v;
			COND_GT: return !f.z && f.n == f.v;
			COND_LE: return f.z || f.n != f.v;
			COND_AL: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign pass = cond_pass(dec.cond, flags);
	assign executing = state == CTRL_EXEC && pass;

	assign take = state == CTRL_IDLE && insn_valid && !halt;
	assign halted = state == CTRL_HALTED;
	assign stop = halted;

	// port b reads rm for operands, rd for store data.
	assign rd_r_a = dec.rn;
	assign rd_r_b = dec.kind == INSN_STR ? dec.rd : dec.rm;
	assign shifter_ctrl = dec.shift;
	assign shifter_base = dec.shift.imm ? {24'b0, dec.imm8} : rd_value_b;
	assign alu_ctrl = dec.op;

	assign wr_r = dec.rd;
	assign wr_value = q_alu;
	assign wr_enable = executing && dec.writes_rd;

	assign store_addr = dec.offset_up ? rd_value_a + {20'b0, dec.offset}
		: rd_value_a - {20'b0, dec.offset};

	assign mem.start = state == CTRL_STORE;
	assign mem.write = 1'b1;
	assign mem.be = 4'b1111;

	always_ff @(posedge clk) begin
		if (take)
			ir <= insn;
		if (state == CTRL_EXEC) begin
			mem.addr <= store_addr[31:2];
			mem.data_wr <= rd_value_b;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CTRL_IDLE;
			flags <= '0;
			breakpoint <= 1'b0;
		end else begin
			case (state)
				CTRL_IDLE:
					if (halt)
						state <= CTRL_HALTED;
					else if (insn_valid)
						state <= CTRL_EXEC;
				CTRL_EXEC: begin
					if (executing && dec.kind == INSN_DP && dec.set_flags) begin
						flags.n <= alu_flags.n;
						flags.z <= alu_flags.z;
						flags.c <= alu_flags.c;
						// logical ops keep v.
						flags.v <= alu_v_valid ? alu_flags.v : flags.v;
					end

					if (executing && dec.kind == INSN_BKPT) begin
						breakpoint <= 1'b1;
						state <= CTRL_HALTED;
					end else if (executing && dec.kind == INSN_STR) begin
						state <= CTRL_STORE;
					end else if (halt) begin
						state <= CTRL_HALTED;
					end else begin
						state <= CTRL_IDLE;
					end
				end
				CTRL_STORE:
					if (mem.ready)
						state <= halt ? CTRL_HALTED : CTRL_IDLE;
				CTRL_HALTED:
					// breakpoint is sticky until reset.
					if (!breakpoint && !halt)
						state <= CTRL_IDLE;
			endcase
		end
	end

	// a take consumes the buffered word.
	assert property (@(posedge clk) disable iff (rst)
		take |-> insn_valid ##1 !insn_valid);

endmodule

`default_nettype wire

// ==== hw/core_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_decode
(
	input  core_pkg::word        insn,
	output core_pkg::insn_decode dec
);
	import core_pkg::*;

	alu_op op;
	logic dp_class, str_class, bkpt_class, op_ok, pc_used;

	assign op = alu_op'(insn[24:21]);

	assign bkpt_class = insn[31:20] == 12'he12 && insn[7:4] == 4'h7;

	// register-shifted operands are not supported.
	assign dp_class = insn[27:26] == 2'b00 && (insn[25] || !insn[4]);

	// immediate offset, pre-indexed, word, no writeback.
	assign str_class = insn[27:25] == 3'b010 && insn[24] && !insn[22]
		&& !insn[21] && !insn[20];

	// the low offset bits of a store are not a register.
	assign pc_used = insn[19:16] == 4'd15 || insn[15:12] == 4'd15
		|| (dp_class && !insn[25] && insn[3:0] == 4'd15);

	always_comb begin
		case (op)
			ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB, ALU_ADD, ALU_ORR, ALU_MOV, ALU_MVN:
				op_ok = 1'b1;
			// without S these encode psr transfers.
			ALU_TST, ALU_CMP:
				op_ok = insn[20];
			default:
				op_ok = 1'b0;
		endcase
	end

	always_comb begin
		dec = '0;
		dec.cond = cond_code'(insn[31:28]);
		dec.op = op;
		dec.set_flags = insn[20];
		dec.rn = insn[19:16];
		dec.rd = insn[15:12];
		dec.rm = insn[3:0];
		dec.imm8 = insn[7:0];
		dec.offset = insn[11:0];
		dec.offset_up = insn[23];

		if (insn[25]) begin
			dec.shift.kind = SHIFT_ROR;
			dec.shift.imm = 1'b1;
			dec.shift.amount = {insn[11:8], 1'b0};
		end else begin
			dec.shift.kind = shift_kind'(insn[6:5]);
			dec.shift.imm = 1'b0;
			dec.shift.amount = insn[11:7];
		end

		if (bkpt_class)
			dec.kind = INSN_BKPT;
		else if (pc_used)
			dec.kind = INSN_UNDEF;
		else if (dp_class && op_ok)
			dec.kind = INSN_DP;
		else if (str_class)
			dec.kind = INSN_STR;
		else
			dec.kind = INSN_UNDEF;

		dec.writes_rd = dec.kind == INSN_DP && op != ALU_TST && op != ALU_CMP;
	end

endmodule

`default_nettype wire

// ==== hw/core_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_fetch
(
	input  logic          clk,
	input  logic          rst,

	core_mem_if.requester mem,

	output logic          insn_valid,
	output core_pkg::word insn,
	output core_pkg::ptr  insn_pc,
	input  logic          take,
	input  logic          stop
);
	import core_pkg::*;

	ptr pc;
	logic busy, fill, launch;

	assign fill = busy && mem.ready;

	// only fetch when the buffer has room for the word.
	assign launch = !stop && !busy && (!insn_valid || take);

	assign mem.start = busy;
	assign mem.addr = pc;
	assign mem.write = 1'b0;
	assign mem.data_wr = '0;
	assign mem.be = 4'b1111;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			insn_valid <= 1'b0;
			pc <= RESET_PC;
		end else begin
			if (launch)
				busy <= 1'b1;
			else if (fill)
				busy <= 1'b0;

			if (fill) begin
				insn_valid <= 1'b1;
				pc <= pc + 30'd1;
			end else if (take) begin
				insn_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			insn <= mem.data_rd;
			insn_pc <= pc;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		mem.start && !mem.ready |=> mem.start && $stable(mem.addr));

endmodule

`default_nettype wire

// ==== hw/core_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface core_mem_if;
	import core_pkg::*;

	ptr         addr;
	logic       start;
	logic       write;
	logic       ready;
	word        data_rd;
	word        data_wr;
	logic [3:0] be;

	modport requester
	(
		output addr, start, write, data_wr, be,
		input  ready, data_rd
	);

	modport arbiter
	(
		input  addr, start, write, data_wr, be,
		output ready, data_rd
	);

endinterface

`default_nettype wire

// ==== hw/core_pkg.sv ====
`default_nettype none

package core_pkg;

	typedef logic [31:0] word;
	typedef logic [29:0] ptr;
	typedef logic [3:0] reg_num;

	// data-processing opcode field, arm encoding.
	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_EOR = 4'b0001,
		ALU_SUB = 4'b0010,
		ALU_RSB = 4'b0011,
		ALU_ADD = 4'b0100,
		ALU_TST = 4'b1000,
		ALU_CMP = 4'b1010,
		ALU_ORR = 4'b1100,
		ALU_MOV = 4'b1101,
		ALU_MVN = 4'b1111
	} alu_op;

	typedef enum logic [1:0] {
		SHIFT_LSL,
		SHIFT_LSR,
		SHIFT_ASR,
		SHIFT_ROR
	} shift_kind;

	typedef struct packed {
		shift_kind  kind;
		logic       imm;
		logic [4:0] amount;
	} shifter_control;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef enum logic [3:0] {
		COND_EQ,
		COND_NE,
		COND_CS,
		COND_CC,
		COND_MI,
		COND_PL,
		COND_VS,
		COND_VC,
		COND_HI,
		COND_LS,
		COND_GE,
		COND_LT,
		COND_GT,
		COND_LE,
		COND_AL,
		COND_NV
	} cond_code;

	typedef enum logic [1:0] {
		INSN_DP,
		INSN_STR,
		INSN_BKPT,
		INSN_UNDEF
	} insn_kind;

	typedef struct packed {
		insn_kind       kind;
		cond_code       cond;
		alu_op          op;
		logic           set_flags;
		reg_num         rn;
		reg_num         rd;
		reg_num         rm;
		shifter_control shift;
		logic [7:0]     imm8;
		logic [11:0]    offset;
		logic           offset_up;
		logic           writes_rd;
	} insn_decode;

	localparam ptr RESET_PC = 30'd0;

endpackage

`default_nettype wire

// ==== hw/core_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_regs
(
	input  logic             clk,
	input  logic             rst,

	input  core_pkg::reg_num rd_r_a,
	input  core_pkg::reg_num rd_r_b,
	output core_pkg::word    rd_value_a,
	output core_pkg::word    rd_value_b,

	input  core_pkg::reg_num wr_r,
	input  logic             wr_enable,
	input  core_pkg::word    wr_value
);
	import core_pkg::*;

	// r0 to r14, pc lives in fetch.
	word file [0:14];

	assign rd_value_a = rd_r_a == 4'd15 ? '0 : file[rd_r_a];
	assign rd_value_b = rd_r_b == 4'd15 ? '0 : file[rd_r_b];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 15; i++)
				file[i] <= '0;
		end else if (wr_enable && wr_r != 4'd15) begin
			file[wr_r] <= wr_value;
		end
	end

endmodule

`default_nettype wire

// ==== hw/core_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_shifter
#(
	parameter int W = 32
)
(
	input  core_pkg::shifter_control ctrl,
	input  logic [W-1:0]             base,
	input  logic                     c_in,
	output logic [W-1:0]             q,
	output logic                     c
);
	import core_pkg::*;

	int unsigned n;
	logic [W-1:0] rot;

	assign n = ctrl.amount;
	assign rot = (base >> n) | (base << (W - n));

	always_comb begin
		q = base;
		c = c_in;

		if (ctrl.imm) begin
			q = rot;
			if (n != 0)
				c = rot[W-1];
		end else begin
			case (ctrl.kind)
				SHIFT_LSL:
					if (n != 0) begin
						q = base << n;
						c = base[W - n];
					end
				// amount zero means 32.
				SHIFT_LSR:
					if (n == 0) begin
						q = '0;
						c = base[W-1];
					end else begin
						q = base >> n;
						c = base[n - 1];
					end
				SHIFT_ASR:
					if (n == 0) begin
						q = {W{base[W-1]}};
						c = base[W-1];
					end else begin
						q = $signed(base) >>> n;
						c = base[n - 1];
					end
				SHIFT_ROR:
					// rrx.
					if (n == 0) begin
						q = {c_in, base[W-1:1]};
						c = base[0];
					end else begin
						q = rot;
						c = base[n - 1];
					end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
hw/core_pkg.sv
hw/core_mem_if.sv
hw/core_fetch.sv
hw/core_decode.sv
hw/core_regs.sv
hw/core_shifter.sv
hw/core_alu.sv
hw/core_control.sv
hw/core_bus_arbiter.sv
hw/arm810.sv
dv/tb_arm810.sv
